/* Makefile */
# Verilator build and run of the receive path testbench

VERILATOR ?= verilator
TOP       ?= tb_cdrx
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
hw/cdrx_pkg.sv
hw/frame_assembler.sv
hw/rx_frame_ram.sv
hw/apb_rx_reader.sv
hw/cdrx_top.sv
test/tb_cdrx.sv

/* hw/apb_rx_reader.sv */
// APB slave on the read side of the frame store
// status, length, byte window and release control,
// one wait state per access, saturating dropped frame counter

`timescale 1ns/1ps

module apb_rx_reader
    import cdrx_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_word_t  pwdata,
    output apb_word_t  prdata,
    output logic       pready,
    output logic       pslverr,

    input  rd_status_t status,
    input  byte_t      rd_byte,
    input  logic       switch_fail,
    output rd_req_t    rd
);

    apb_state_t state;
    apb_addr_t  addr_q;
    logic       write_q;
    logic [1:0] ctrl_q;         // done_all, done
    byte_t      drop_cnt;
    logic       in_window;
    logic       sel_status;
    logic       sel_len;
    logic       sel_ctrl;

    assign in_window  = addr_q[11:10] == DATA_BASE[11:10];
    assign sel_status = addr_q == REG_STATUS;
    assign sel_len    = addr_q == REG_LEN;
    assign sel_ctrl   = addr_q == REG_CTRL;

    // only CTRL takes writes
    assign pslverr = pready &&
                     (write_q ? !sel_ctrl : !(in_window || sel_status || sel_len || sel_ctrl));

    always_comb begin
        prdata = '0;
        if (in_window)
            prdata[7:0] = rd_byte;
        else if (sel_status)
            prdata = {16'd0, drop_cnt, 6'd0, status.err, status.unread};
        else if (sel_len)
            prdata[7:0] = status.len;
    end

    always_ff @(posedge clk) begin
        if (state == APB_IDLE && psel && !penable) begin
            addr_q <= paddr;
            ctrl_q <= pwdata[1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= APB_IDLE;
            pready  <= 1'b0;
            write_q <= 1'b0;
            rd      <= '0;
        end else begin
            rd.en       <= 1'b0;
            rd.done     <= 1'b0;
            rd.done_all <= 1'b0;

            case (state)
                APB_IDLE: begin
                    if (psel && !penable) begin     // setup phase
                        state   <= APB_ACCESS;
                        write_q <= pwrite;
                        rd.en   <= !pwrite && paddr[11:10] == DATA_BASE[11:10];
                        rd.addr <= paddr[9:2];      // byte read lands before WAIT
                    end
                end
                APB_ACCESS: begin
                    state  <= APB_WAIT;
                    pready <= 1'b1;
                    if (write_q && sel_ctrl) begin
                        rd.done     <= ctrl_q[0];
                        rd.done_all <= ctrl_q[1];
                    end
                end
                default: begin
                    state  <= APB_IDLE;
                    pready <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            drop_cnt <= '0;
        else if (rd.done_all)
            drop_cnt <= '0;
        else if (switch_fail && drop_cnt != 8'hff)
            drop_cnt <= drop_cnt + 8'd1;    // saturates at 255
    end

    a_ready_wait: assert property (
        @(posedge clk) disable iff (!reset_n)
        pready |-> state == APB_WAIT
    ) else $error("pready outside the wait state");

endmodule

/* hw/cdrx_pkg.sv */
// shared types for the multidrop bus receive path
// byte and length types, write/commit/read structs,
// FSM state enums and the APB register map

package cdrx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  frame_len_t;   // length minus one, 0 means 1 byte
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_word_t;

    // one byte into the frame being received
    typedef struct packed {
        logic  en;
        byte_t addr;    // offset within the frame
        byte_t data;
    } rx_wr_t;

    // end of frame, pulsed once per frame
    typedef struct packed {
        logic       switch;
        frame_len_t len;
        logic       err;
    } rx_commit_t;

    // consumer side requests
    typedef struct packed {
        logic  en;
        byte_t addr;
        logic  done;        // release the oldest frame
        logic  done_all;    // drop everything
    } rd_req_t;

    // state of the oldest stored frame
    typedef struct packed {
        logic       unread;
        logic       err;
        frame_len_t len;
    } rd_status_t;

    typedef enum logic [1:0] {
        ASM_IDLE,
        ASM_RECV,
        ASM_DROP
    } asm_state_t;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_ACCESS,
        APB_WAIT
    } apb_state_t;

    localparam apb_addr_t REG_STATUS = 12'h000;
    localparam apb_addr_t REG_LEN    = 12'h004;
    localparam apb_addr_t REG_CTRL   = 12'h008;
    localparam apb_addr_t DATA_BASE  = 12'h400;   // byte k at DATA_BASE + 4k

endpackage

/* hw/cdrx_top.sv */
// receive path top level
// frame assembler, slotted frame RAM and APB reader

`timescale 1ns/1ps

module cdrx_top
    import cdrx_pkg::*;
#(
    parameter int I_WIDTH = 6,      // 64 slots
    parameter int B_WIDTH = 11      // 2048 bytes
) (
    input  logic      clk,
    input  logic      reset_n,

    input  logic      rx_valid,
    input  byte_t     rx_byte,
    input  logic      rx_end,
    input  logic      rx_err,

    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_word_t pwdata,
    output apb_word_t prdata,
    output logic      pready,
    output logic      pslverr
);

    rx_wr_t     wr;
    rx_commit_t commit;
    rd_req_t    rd;
    rd_status_t status;
    byte_t      rd_byte;
    logic       switch_fail;

    frame_assembler asm0 (
        .clk(clk),
        .reset_n(reset_n),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte),
        .rx_end(rx_end),
        .rx_err(rx_err),
        .wr(wr),
        .commit(commit)
    );

    rx_frame_ram #(
        .I_WIDTH(I_WIDTH),
        .B_WIDTH(B_WIDTH)
    ) ram0 (
        .clk(clk),
        .reset_n(reset_n),
        .wr(wr),
        .commit(commit),
        .rd(rd),
        .rd_byte(rd_byte),
        .status(status),
        .switch_fail(switch_fail)
    );

    apb_rx_reader apb0 (
        .clk(clk),
        .reset_n(reset_n),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .status(status),
        .rd_byte(rd_byte),
        .switch_fail(switch_fail),
        .rd(rd)
    );

endmodule

/* hw/frame_assembler.sv */
// frame assembler for the receive byte stream
// numbers the bytes of each frame, writes them to the frame RAM
// and issues one commit with length and error at the frame's end

`timescale 1ns/1ps

module frame_assembler
    import cdrx_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    input  logic       rx_valid,
    input  byte_t      rx_byte,
    input  logic       rx_end,      // last byte of the frame
    input  logic       rx_err,

    output rx_wr_t     wr,
    output rx_commit_t commit
);

    asm_state_t state;
    byte_t      cnt;        // offset of the next byte, wraps after 256
    logic       err_acc;    // any bad byte so far

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= ASM_IDLE;
            cnt     <= '0;
            err_acc <= 1'b0;
            wr      <= '0;
            commit  <= '0;
        end else begin
            wr.en         <= 1'b0;
            commit.switch <= 1'b0;

            if (rx_valid) begin
                case (state)
                    ASM_IDLE: begin
                        // first byte always lands at offset 0
                        wr      <= '{en: 1'b1, addr: '0, data: rx_byte};
                        cnt     <= 8'd1;
                        err_acc <= rx_err;
                        if (rx_end)
                            commit <= '{switch: 1'b1, len: '0, err: rx_err};
                        else
                            state <= ASM_RECV;
                    end

                    ASM_RECV: begin
                        if (cnt == '0) begin
                            // byte 257, frame too long for the length field
                            state <= rx_end ? ASM_IDLE : ASM_DROP;
                        end else begin
                            wr      <= '{en: 1'b1, addr: cnt, data: rx_byte};
                            cnt     <= cnt + 8'd1;
                            err_acc <= err_acc | rx_err;
                            if (rx_end) begin
                                commit <= '{switch: 1'b1, len: cnt, err: err_acc | rx_err};
                                state  <= ASM_IDLE;
                            end
                        end
                    end

                    default: begin  // ASM_DROP, swallow the rest silently
                        if (rx_end)
                            state <= ASM_IDLE;
                    end
                endcase
            end
        end
    end

    // bus frames always carry a header, so two frame ends are never
    // adjacent and the RAM sees each commit after its write pointer settles
    a_single_commit: assert property (
        @(posedge clk) disable iff (!reset_n)
        commit.switch |=> !commit.switch
    ) else $error("back to back frame commits");

endmodule

/* hw/rx_frame_ram.sv */
// slotted receive frame store
// byte memory split into fixed slots, a frame takes one or more
// consecutive slots; per slot index table, dirty and error bits,
// commit or cancel on frame end, in-order release on the read side

`timescale 1ns/1ps

module rx_frame_ram
    import cdrx_pkg::*;
#(
    parameter int I_WIDTH = 6,      // slot index width
    parameter int B_WIDTH = 11      // byte address width
) (
    input  logic       clk,
    input  logic       reset_n,

    input  rx_wr_t     wr,
    input  rx_commit_t commit,
    input  rd_req_t    rd,

    output byte_t      rd_byte,
    output rd_status_t status,
    output logic       switch_fail
);

    localparam int S_WIDTH = B_WIDTH - I_WIDTH;     // log2 of bytes per slot
    localparam int F_WIDTH = 8 - S_WIDTH;           // extra slots a frame may use
    localparam int SLOTS   = 2 ** I_WIDTH;

    typedef struct packed {
        logic [F_WIDTH-1:0] frags;  // slots beyond the first
        frame_len_t         len;
    } idx_entry_t;

    logic [I_WIDTH-1:0] wr_sel;     // first slot of the frame being written
    logic [I_WIDTH-1:0] rd_sel;     // first slot of the oldest frame
    logic [I_WIDTH-1:0] wr_slot;
    logic [SLOTS-1:0]   dirty;      // set on the first slot of stored frames only
    logic [SLOTS-1:0]   error;

    idx_entry_t         idx_table [SLOTS];
    idx_entry_t         idx_rd_val;
    byte_t              mem [2 ** B_WIDTH];

    logic               wr_cancel;
    logic               wr_en_d;
    byte_t              wr_data_d;
    logic [B_WIDTH-1:0] buf_wr_addr;
    logic [B_WIDTH-1:0] buf_rd_addr;
    logic [F_WIDTH-1:0] wr_frags;
    logic               switch_d;
    frame_len_t         len_d;
    logic               err_d;
    logic               commit_ok;

    assign wr_slot     = wr_sel + I_WIDTH'(wr.addr[7:S_WIDTH]);
    assign buf_rd_addr = {rd_sel, {S_WIDTH{1'b0}}} + B_WIDTH'(rd.addr);   // wraps
    assign commit_ok   = switch_d && !wr_cancel;

    // the oldest frame is unread as long as its first slot is dirty
    assign status = '{unread: dirty[rd_sel], err: error[rd_sel], len: idx_rd_val.len};

    always_ff @(posedge clk) begin
        buf_wr_addr <= {wr_slot, wr.addr[S_WIDTH-1:0]};
        wr_data_d   <= wr.data;
        len_d       <= commit.len;
        err_d       <= commit.err;
        idx_rd_val  <= idx_table[rd_sel];

        if (commit_ok)
            idx_table[wr_sel] <= '{frags: wr_frags, len: len_d};
        if (wr_en_d)
            mem[buf_wr_addr] <= wr_data_d;
        if (rd.en)
            rd_byte <= mem[buf_rd_addr];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            switch_fail <= 1'b0;
            wr_sel      <= '0;
            rd_sel      <= '0;
            dirty       <= '0;
            error       <= '0;
            wr_cancel   <= 1'b0;
            wr_en_d     <= 1'b0;
            wr_frags    <= '0;
            switch_d    <= 1'b0;
        end else begin
            switch_fail <= 1'b0;
            wr_en_d     <= 1'b0;
            switch_d    <= commit.switch;

            // offset 0 opens a new frame and redoes the dirty check
            if (wr.en && (!wr_cancel || wr.addr == '0)) begin
                if (dirty[wr_slot]) begin
                    wr_cancel <= 1'b1;      // rest of the frame is discarded
                end else begin
                    wr_cancel <= 1'b0;
                    wr_en_d   <= 1'b1;
                    wr_frags  <= wr.addr[7:S_WIDTH];
                end
            end

            if (switch_d) begin
                if (wr_cancel) begin
                    switch_fail <= 1'b1;
                end else begin
                    dirty[wr_sel] <= 1'b1;
                    error[wr_sel] <= err_d;
                    wr_sel        <= wr_sel + I_WIDTH'(wr_frags) + I_WIDTH'(1);
                end
                wr_cancel <= 1'b0;
            end

            if (rd.done && dirty[rd_sel]) begin
                dirty[rd_sel] <= 1'b0;
                rd_sel        <= rd_sel + I_WIDTH'(idx_rd_val.frags) + I_WIDTH'(1);
            end

            if (rd.done_all) begin
                switch_fail <= 1'b0;
                wr_sel      <= '0;
                rd_sel      <= '0;
                dirty       <= '0;
                wr_cancel   <= 1'b0;
                switch_d    <= 1'b0;
            end
        end
    end

    a_write_clean: assert property (
        @(posedge clk) disable iff (!reset_n)
        wr_en_d |-> !dirty[buf_wr_addr[B_WIDTH-1:S_WIDTH]]
    ) else $error("byte written into a stored frame");

    a_rd_move: assert property (
        @(posedge clk) disable iff (!reset_n)
        $changed(rd_sel) |-> $past(rd.done_all || (rd.done && dirty[rd_sel]))
    ) else $error("read slot moved without a release");

endmodule

/* test/cdrx_golden.txt */
# F len err keep count fill | R len err keep count | T status | L len | D first count
# X count | C | E addr ; fill, status, len and addr in hex, the rest decimal
F 5 0 1 1 10
T 001
L 04
D 0 5
X 1
T 000
R 7 1 1 1
R 9 0 1 1
T 003
D 0 7
X 1
T 001
L 08
D 0 9
X 1
E 000
E 800
R 256 0 1 7
X 7
F 3 0 1 1 20
R 40 0 1 1
R 100 0 1 1
L 02
D 0 3
X 1
L 27
D 0 40
X 1
L 63
D 0 100
X 1
R 256 0 1 8
R 256 0 0 1
T 101
D 0 256
X 1
F 32 0 1 1 c0
T 101
C
T 000
F 20 0 1 1 a0
T 001
L 13
D 0 20
X 1

/* test/tb_cdrx.sv */
// testbench for the receive path top level
// clock and reset, byte stream driver, APB master tasks,
// golden file interpreter with a model of the stored frames, watchdog

`timescale 1ns/1ps

module tb_cdrx
    import cdrx_pkg::*;
();

    logic      clk;
    logic      reset_n;
    logic      rx_valid;
    byte_t     rx_byte;
    logic      rx_end;
    logic      rx_err;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_word_t pwdata;
    apb_word_t prdata;
    logic      pready;
    logic      pslverr;

    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    int        cycle_limit = 400;   // grows with every golden command
    byte_t     model_data[$];       // bytes of the stored frames, oldest first
    int        model_len[$];

    cdrx_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s got %0h expected %0h", name, got, exp);
        end
    endtask

    // one APB transfer, the slave answers after exactly one wait state
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_word_t wdata,
                              output apb_word_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_value("pready", 32'(pready), 32'd0);  // wait state
        @(negedge clk);
        check_value("pready", 32'(pready), 32'd1);
        rdata = prdata;     // stable between edges
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_word(input apb_addr_t addr, output apb_word_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic write_word(input apb_addr_t addr, input apb_word_t data, input logic exp_err);
        apb_word_t unused;
        logic      err;
        apb_access(1'b1, addr, data, unused, err);
        check_value("pslverr", 32'(err), 32'(exp_err));
    endtask

    // fill < 0 draws random bytes, rx_err goes on the middle byte
    task automatic send_frame(input int len, input logic err, input logic keep, input int fill);
        byte_t b;
        for (int k = 0; k < len; k++) begin
            b = (fill < 0) ? byte_t'($urandom) : byte_t'(fill + k);
            if (keep)
                model_data.push_back(b);
            @(posedge clk);
            rx_valid <= 1'b1;
            rx_byte  <= b;
            rx_end   <= (k == len - 1);
            rx_err   <= err && (k == len / 2);
        end
        if (keep)
            model_len.push_back(len);
        @(posedge clk);
        rx_valid <= 1'b0;
        rx_end   <= 1'b0;
        rx_err   <= 1'b0;
        repeat ($urandom_range(6, 3)) @(posedge clk);  // idle gap between frames
    endtask

    task automatic check_bytes(input int first, input int count);
        apb_word_t data;
        if (model_len.size() == 0) begin
            errors++;
            $display("byte read requested but no frame is expected in the buffer");
            return;
        end
        for (int k = first; k < first + count; k++) begin
            read_word(DATA_BASE + apb_addr_t'(4 * k), data);
            check_value($sformatf("prdata[byte %0d]", k), data, {24'd0, model_data[k]});
        end
    endtask

    task automatic release_frames(input int count);
        repeat (count) begin
            write_word(REG_CTRL, 32'h1, 1'b0);
            if (model_len.size() > 0) begin
                repeat (model_len[0]) void'(model_data.pop_front());
                void'(model_len.pop_front());
            end
        end
    endtask

    initial begin
        int         fd;
        logic [7:0] cmd;
        int         a;
        int         b;
        int         c;
        int         d;
        int         e;
        string      line;
        apb_word_t  data;

        void'($urandom(32'h4ffe_74d8));
        reset_n  = 1'b0;
        rx_valid = 1'b0;
        rx_byte  = '0;
        rx_end   = 1'b0;
        rx_err   = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        fd = $fopen("test/cdrx_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the golden file test/cdrx_golden.txt");
        end else begin
            while ($fscanf(fd, " %c", cmd) == 1) begin
                cycle_limit += 200;
                case (cmd)
                    "#": void'($fgets(line, fd));
                    "F", "R": begin
                        if (cmd == "F") begin
                            void'($fscanf(fd, "%d %d %d %d %h", a, b, c, d, e));
                        end else begin
                            void'($fscanf(fd, "%d %d %d %d", a, b, c, d));
                            e = -1;
                        end
                        cycle_limit += 50 * a * d;
                        repeat (d) send_frame(a, b[0], c[0], e);
                    end
                    "T": begin
                        void'($fscanf(fd, "%h", a));
                        read_word(REG_STATUS, data);
                        check_value("STATUS", data, a);
                    end
                    "L": begin
                        void'($fscanf(fd, "%h", a));
                        read_word(REG_LEN, data);
                        check_value("LEN", data, a);
                    end
                    "D": begin
                        void'($fscanf(fd, "%d %d", a, b));
                        check_bytes(a, b);
                    end
                    "X": begin
                        void'($fscanf(fd, "%d", a));
                        release_frames(a);
                    end
                    "C": begin
                        write_word(REG_CTRL, 32'h2, 1'b0);
                        model_data.delete();
                        model_len.delete();
                    end
                    "E": begin
                        void'($fscanf(fd, "%h", a));
                        write_word(apb_addr_t'(a), 32'h0, 1'b1);
                    end
                    default: begin
                        errors++;
                        $display("unknown golden command %c", cmd);
                    end
                endcase
            end
            $fclose(fd);
        end

        repeat (5) @(posedge clk);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // watchdog, the limit follows the commands read so far
    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("Checks failed");
        $finish;
    end

endmodule
